// ==== hdl/imuldiv_pkg.sv ====
// shared constants for the iterative multiply/divide unit
// function codes, controller states and the result word union

package imuldiv_pkg;

  // operand width
  localparam int XLEN = 32;

  // iteration counter width, one step per operand bit
  localparam int CNT_W = 5;

  // request side holds a single credit, one operation in flight
  localparam int REQ_CREDITS = 1;

  // function codes as carried on req_fn
  typedef enum logic [2:0] {
    FN_MUL  = 3'd0,
    FN_DIV  = 3'd1,
    FN_DIVU = 3'd2,
    FN_REM  = 3'd3,
    FN_REMU = 3'd4
  } imuldiv_fn_t;

  // controller sequence
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_FIX  = 2'd2,
    ST_DONE = 2'd3
  } imuldiv_state_t;

  // ----------------------------
  // result word, read as product halves or as {remainder, quotient}
  typedef union packed {
    struct packed {
      logic [XLEN-1:0] hi;
      logic [XLEN-1:0] lo;
    } prod;
    struct packed {
      logic [XLEN-1:0] rem;
      logic [XLEN-1:0] quot;
    } div;
  } imuldiv_result_u;

endpackage

// ==== hdl/imuldiv_ctrl.sv ====
`timescale 1ns/1ps
// controller for the iterative mul/div unit
// state sequence, step counter and both credit counters

module imuldiv_ctrl #(
  parameter int RESP_CREDITS = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  input  imuldiv_pkg::imuldiv_fn_t req_fn,
  input  logic                     resp_credit,
  output logic                     req_credit,
  output logic                     resp_val,
  output logic                     op_load,
  output logic                     mul_load,
  output logic                     mul_step,
  output logic                     div_load,
  output logic                     div_step,
  output logic                     fix_en
);
  import imuldiv_pkg::*;

  // counters must reach their full credit value
  localparam int RC_W = $clog2(RESP_CREDITS + 1);
  localparam int QC_W = $clog2(REQ_CREDITS + 1);

  imuldiv_state_t   state;
  logic [CNT_W-1:0] step_cnt;
  logic             op_is_mul;
  logic [RC_W-1:0]  resp_cnt;
  logic [QC_W-1:0]  req_cnt;
  logic             accept;
  logic             send_go;

  // request taken only when idle and the requester spent a credit
  assign accept = req_val && (state == ST_IDLE) && (req_cnt != '0);

  // a credit returned this cycle can be spent right away
  assign send_go = (state == ST_DONE) && ((resp_cnt != '0) || resp_credit);

  // ----------------------------
  // state sequence
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      step_cnt  <= '0;
      op_is_mul <= 1'b0;
      resp_val  <= 1'b0;
    end else begin
      // one cycle pulse per result
      resp_val <= send_go;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state     <= ST_CALC;
            step_cnt  <= '0;
            op_is_mul <= (req_fn == FN_MUL);
          end
        end
        ST_CALC: begin
          step_cnt <= step_cnt + CNT_W'(1);
          // last of the XLEN shift steps
          if (step_cnt == CNT_W'(XLEN - 1)) begin
            state <= ST_FIX;
          end
        end
        ST_FIX: begin
          state <= ST_DONE;
        end
        ST_DONE: begin
          // wait here with the result held until a credit shows up
          if (send_go) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------
  // credit counters
  // resp side counts consumer slots, req side mirrors the requester
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_cnt <= RC_W'(RESP_CREDITS);
      req_cnt  <= QC_W'(REQ_CREDITS);
    end else begin
      resp_cnt <= resp_cnt + RC_W'(resp_credit) - RC_W'(resp_val);
      req_cnt  <= req_cnt - QC_W'(accept) + QC_W'(req_credit);
    end
  end

  // request credit goes back with the response
  assign req_credit = resp_val;

  // datapath controls
  assign op_load  = accept;
  assign mul_load = accept && (req_fn == FN_MUL);
  assign div_load = accept && (req_fn != FN_MUL);
  assign mul_step = (state == ST_CALC) && op_is_mul;
  assign div_step = (state == ST_CALC) && !op_is_mul;
  assign fix_en   = (state == ST_FIX);

  // ----------------------------
  // protocol checks
  a_resp_has_credit: assert property (
    @(posedge clk) disable iff (reset) resp_val |-> (resp_cnt != '0)
  );

  a_resp_cnt_max: assert property (
    @(posedge clk) disable iff (reset) resp_cnt <= RESP_CREDITS
  );

  a_req_in_idle: assert property (
    @(posedge clk) disable iff (reset)
      req_val |-> (state == ST_IDLE) && (req_cnt != '0)
  );

endmodule

// ==== hdl/imuldiv_mul_dpath.sv ====
`timescale 1ns/1ps
// shift-add multiplier datapath
// takes operand magnitudes, one partial product per step

module imuldiv_mul_dpath (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           mul_load,
  input  logic                           mul_step,
  input  logic [imuldiv_pkg::XLEN-1:0]   req_a,
  input  logic [imuldiv_pkg::XLEN-1:0]   req_b,
  output logic [2*imuldiv_pkg::XLEN-1:0] prod_mag
);
  import imuldiv_pkg::*;

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] mcand;
  logic [XLEN-1:0]   mplier;
  logic [2*XLEN-1:0] acc;
  logic [2*XLEN-1:0] acc_next;

  // two's complement magnitudes, mul is always signed
  assign a_mag = req_a[XLEN-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[XLEN-1] ? (~req_b + 1'b1) : req_b;

  // add the shifted multiplicand when the low multiplier bit is set
  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  // ----------------------------
  // operand shifters
  always_ff @(posedge clk) begin
    if (mul_load) begin
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
    end else if (mul_step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (mul_load) begin
      acc <= '0;
    end else if (mul_step) begin
      acc <= acc_next;
    end
  end

  assign prod_mag = acc;

  // controller never loads and shifts in the same cycle
  a_load_step_excl: assert property (
    @(posedge clk) disable iff (reset) !(mul_load && mul_step)
  );

endmodule

// ==== hdl/imuldiv_div_dpath.sv ====
`timescale 1ns/1ps
// restoring shift-subtract divider datapath
// magnitudes for signed codes, zero divisor flag, one quotient bit per step

module imuldiv_div_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         div_load,
  input  logic                         div_step,
  input  imuldiv_pkg::imuldiv_fn_t     req_fn,
  input  logic [imuldiv_pkg::XLEN-1:0] req_a,
  input  logic [imuldiv_pkg::XLEN-1:0] req_b,
  output logic [imuldiv_pkg::XLEN-1:0] quot_mag,
  output logic [imuldiv_pkg::XLEN-1:0] rem_mag,
  output logic                         div_by_zero
);
  import imuldiv_pkg::*;

  logic            is_signed;
  logic [XLEN-1:0] dvd_mag;
  logic [XLEN-1:0] dvs_mag;
  logic [XLEN-1:0] quot_q;
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] dvs_q;
  logic [XLEN:0]   shifted;
  logic [XLEN+1:0] diff;

  // only div and rem treat the operands as signed
  assign is_signed = (req_fn == FN_DIV) || (req_fn == FN_REM);

  assign dvd_mag = (is_signed && req_a[XLEN-1]) ? (~req_a + 1'b1) : req_a;
  assign dvs_mag = (is_signed && req_b[XLEN-1]) ? (~req_b + 1'b1) : req_b;

  // ----------------------------
  // partial remainder with the next dividend bit shifted in
  // quot_q starts as the dividend and fills with quotient bits from the right
  assign shifted = {rem_q, quot_q[XLEN-1]};

  // extra top bit acts as the borrow
  assign diff = {1'b0, shifted} - {2'b00, dvs_q};

  always_ff @(posedge clk) begin
    if (div_load) begin
      quot_q <= dvd_mag;
      rem_q  <= '0;
      dvs_q  <= dvs_mag;
    end else if (div_step) begin
      if (!diff[XLEN+1]) begin
        // divisor fits, keep the difference
        rem_q  <= diff[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b1};
      end else begin
        // restore, partial remainder stays as shifted
        rem_q  <= shifted[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // zero divisor is noted at load, the result unit overrides the quotient
  always_ff @(posedge clk) begin
    if (reset) begin
      div_by_zero <= 1'b0;
    end else if (div_load) begin
      div_by_zero <= (req_b == '0);
    end
  end

  assign quot_mag = quot_q;
  assign rem_mag  = rem_q;

endmodule

// ==== hdl/imuldiv_result_unit.sv ====
`timescale 1ns/1ps
// result unit, sign restore and divide-by-zero override
// packs the final word through the union and holds it for the response

module imuldiv_result_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           op_load,
  input  logic                           fix_en,
  input  imuldiv_pkg::imuldiv_fn_t       req_fn,
  input  logic                           req_a_sign,
  input  logic                           req_b_sign,
  input  logic [2*imuldiv_pkg::XLEN-1:0] prod_mag,
  input  logic [imuldiv_pkg::XLEN-1:0]   quot_mag,
  input  logic [imuldiv_pkg::XLEN-1:0]   rem_mag,
  input  logic                           div_by_zero,
  output imuldiv_pkg::imuldiv_result_u   resp_result
);
  import imuldiv_pkg::*;

  imuldiv_fn_t       fn_q;
  logic              a_sign_q;
  logic              b_sign_q;
  logic              signed_div;
  logic              prod_neg;
  logic              quot_neg;
  logic              rem_neg;
  logic [2*XLEN-1:0] prod_fix;
  imuldiv_result_u   result_d;

  // operation info captured when the request is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q     <= FN_MUL;
      a_sign_q <= 1'b0;
      b_sign_q <= 1'b0;
    end else if (op_load) begin
      fn_q     <= req_fn;
      a_sign_q <= req_a_sign;
      b_sign_q <= req_b_sign;
    end
  end

  // ----------------------------
  // sign rules
  assign signed_div = (fn_q == FN_DIV) || (fn_q == FN_REM);
  assign prod_neg   = a_sign_q ^ b_sign_q;
  // quotient truncates toward zero
  assign quot_neg   = signed_div && (a_sign_q ^ b_sign_q);
  // remainder follows the dividend
  assign rem_neg    = signed_div && a_sign_q;

  assign prod_fix = prod_neg ? (~prod_mag + 1'b1) : prod_mag;

  always_comb begin
    result_d = '0;
    if (fn_q == FN_MUL) begin
      result_d.prod.hi = prod_fix[2*XLEN-1:XLEN];
      result_d.prod.lo = prod_fix[XLEN-1:0];
    end else begin
      // zero divisor gives all ones, remainder comes out as the dividend
      if (div_by_zero) begin
        result_d.div.quot = '1;
      end else begin
        result_d.div.quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
      end
      result_d.div.rem = rem_neg ? (~rem_mag + 1'b1) : rem_mag;
    end
  end

  // held until the next fix cycle
  always_ff @(posedge clk) begin
    if (fix_en) begin
      resp_result <= result_d;
    end
  end

endmodule

// ==== hdl/imuldiv_iterative.sv ====
`timescale 1ns/1ps
// top level of the iterative mul/div unit
// controller, multiplier, divider and result unit

module imuldiv_iterative #(
  parameter int RESP_CREDITS = 2
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  input  imuldiv_pkg::imuldiv_fn_t     req_fn,
  input  logic [imuldiv_pkg::XLEN-1:0] req_a,
  input  logic [imuldiv_pkg::XLEN-1:0] req_b,
  input  logic                         resp_credit,
  output logic                         req_credit,
  output logic                         resp_val,
  output imuldiv_pkg::imuldiv_result_u resp_result
);
  import imuldiv_pkg::*;

  // controls
  logic op_load;
  logic mul_load;
  logic mul_step;
  logic div_load;
  logic div_step;
  logic fix_en;

  // datapath results
  logic [2*XLEN-1:0] prod_mag;
  logic [XLEN-1:0]   quot_mag;
  logic [XLEN-1:0]   rem_mag;
  logic              div_by_zero;

  // ----------------------------
  imuldiv_ctrl #(
    .RESP_CREDITS (RESP_CREDITS)
  ) ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .resp_credit (resp_credit),
    .req_credit  (req_credit),
    .resp_val    (resp_val),
    .op_load     (op_load),
    .mul_load    (mul_load),
    .mul_step    (mul_step),
    .div_load    (div_load),
    .div_step    (div_step),
    .fix_en      (fix_en)
  );

  imuldiv_mul_dpath mul (
    .clk      (clk),
    .reset    (reset),
    .mul_load (mul_load),
    .mul_step (mul_step),
    .req_a    (req_a),
    .req_b    (req_b),
    .prod_mag (prod_mag)
  );

  imuldiv_div_dpath div (
    .clk         (clk),
    .reset       (reset),
    .div_load    (div_load),
    .div_step    (div_step),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .div_by_zero (div_by_zero)
  );

  // operand sign bits taken straight off the request
  imuldiv_result_unit result (
    .clk         (clk),
    .reset       (reset),
    .op_load     (op_load),
    .fix_en      (fix_en),
    .req_fn      (req_fn),
    .req_a_sign  (req_a[XLEN-1]),
    .req_b_sign  (req_b[XLEN-1]),
    .prod_mag    (prod_mag),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .div_by_zero (div_by_zero),
    .resp_result (resp_result)
  );

endmodule

// ==== tests/imuldiv_tb.sv ====
`timescale 1ns/1ps
// testbench for the iterative mul/div unit
// clock, credit models, reference model and directed tests

module imuldiv_tb;
  import imuldiv_pkg::*;

  localparam int RESP_CREDITS = 2;
  // resp_val is high in the cycle that begins this many edges after E0
  localparam int LATENCY = 34;
  localparam int TIMEOUT = 100;

  logic            clk;
  logic            reset;
  logic            req_val;
  imuldiv_fn_t     req_fn;
  logic [XLEN-1:0] req_a;
  logic [XLEN-1:0] req_b;
  logic            resp_credit = 1'b0;
  logic            req_credit;
  logic            resp_val;
  imuldiv_result_u resp_result;

  // edge count and credit bookkeeping for both sides
  int              edge_cnt = 0;
  int              last_e0 = 0;
  int              req_issued = 0;
  int              req_returned = 0;
  int              resp_seen = 0;
  int              credits_returned = 0;
  int              unit_cr = RESP_CREDITS;
  bit              hold_credits = 1'b0;
  imuldiv_result_u resp_q[$];
  int              resp_edge_q[$];

  imuldiv_iterative #(
    .RESP_CREDITS (RESP_CREDITS)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_credit (resp_credit),
    .req_credit  (req_credit),
    .resp_val    (resp_val),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // reporting
  task automatic stop_run(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      stop_run("value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout after %0d cycles, %s", TIMEOUT, what);
    stop_run("wait timed out");
  endtask

  // ------------------------------
  // reference model, straight from the result rules
  function automatic logic [63:0] model_result(input imuldiv_fn_t fn,
                                               input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [31:0] uq;
    logic [31:0] ur;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == FN_MUL) begin
      return sa * sb;
    end
    // 64-bit math keeps min / -1 in range, low half is the wrapped quotient
    if (fn == FN_DIV || fn == FN_REM) begin
      if (b == '0) begin
        q = -1;
        r = sa;
      end else begin
        q = sa / sb;
        r = sa % sb;
      end
      return {r[31:0], q[31:0]};
    end
    if (b == '0) begin
      uq = '1;
      ur = a;
    end else begin
      uq = a / b;
      ur = a % b;
    end
    return {ur, uq};
  endfunction

  // ------------------------------
  // response monitor, sampled on the rising edge
  always @(posedge clk) begin
    if (!reset) begin
      edge_cnt++;
      check_equal("req_credit with resp_val", resp_val, req_credit);
      if (resp_val) begin
        // unit may only send while it holds a consumer credit
        check_equal("resp_val with unit credit", 1, unit_cr > 0);
        resp_q.push_back(resp_result);
        resp_edge_q.push_back(edge_cnt);
        resp_seen++;
      end
      if (req_credit) begin
        req_returned++;
      end
      unit_cr = unit_cr + int'(resp_credit) - int'(resp_val);
    end
  end

  // consumer model, one credit pulse per cycle unless holding
  always @(posedge clk) begin
    #1;
    if (!reset && !hold_credits && (resp_seen - credits_returned > 0)) begin
      resp_credit = 1'b1;
      credits_returned++;
    end else begin
      resp_credit = 1'b0;
    end
  end

  // ------------------------------
  // request driver and waits, all entered 1 ns after an edge
  task automatic issue_op(input imuldiv_fn_t fn, input logic [31:0] a, input logic [31:0] b);
    int waited;
    waited = 0;
    while (REQ_CREDITS - req_issued + req_returned == 0) begin
      if (waited == TIMEOUT) fail_timeout("request credit never came back");
      @(posedge clk);
      #1;
      waited++;
    end
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_issued++;
    // next edge samples req_val
    last_e0 = edge_cnt + 1;
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic wait_resp(output imuldiv_result_u got, output int resp_edge);
    int waited;
    waited = 0;
    while (resp_q.size() == 0) begin
      if (waited == TIMEOUT) fail_timeout("resp_val never arrived");
      @(posedge clk);
      #1;
      waited++;
    end
    got       = resp_q.pop_front();
    resp_edge = resp_edge_q.pop_front();
  endtask

  task automatic wait_credits_home();
    int waited;
    waited = 0;
    while (resp_seen - credits_returned != 0 || unit_cr != RESP_CREDITS) begin
      if (waited == TIMEOUT) fail_timeout("consumer credits never returned to the unit");
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // issue one op, wait for it and compare both halves
  task automatic run_op(input string name, input imuldiv_fn_t fn, input logic [31:0] a,
                        input logic [31:0] b, input bit check_lat);
    imuldiv_result_u exp;
    imuldiv_result_u got;
    int              resp_edge;
    exp = model_result(fn, a, b);
    issue_op(fn, a, b);
    wait_resp(got, resp_edge);
    if (fn == FN_MUL) begin
      check_equal({name, " hi"}, exp.prod.hi, got.prod.hi);
      check_equal({name, " lo"}, exp.prod.lo, got.prod.lo);
    end else begin
      check_equal({name, " rem"}, exp.div.rem, got.div.rem);
      check_equal({name, " quot"}, exp.div.quot, got.div.quot);
    end
    // sampled one edge after the cycle it is high in
    if (check_lat) check_equal({name, " latency"}, LATENCY, resp_edge - 1 - last_e0);
  endtask

  // ------------------------------
  // directed tests
  task automatic test_mul_signs();
    run_op("mul pos pos", FN_MUL, 32'd7, 32'd3, 1);
    run_op("mul neg pos", FN_MUL, -32'sd7, 32'd3, 1);
    run_op("mul pos neg", FN_MUL, 32'd123456, -32'sd789, 1);
    run_op("mul neg neg", FN_MUL, -32'sd65536, -32'sd65537, 1);
    run_op("mul zero", FN_MUL, 32'd0, -32'sd5, 1);
    run_op("mul min by one", FN_MUL, 32'h8000_0000, 32'd1, 1);
    run_op("mul min by min", FN_MUL, 32'h8000_0000, 32'h8000_0000, 1);
    run_op("mul min by minus one", FN_MUL, 32'h8000_0000, 32'hFFFF_FFFF, 1);
  endtask

  task automatic test_div_rem();
    run_op("div pos pos", FN_DIV, 32'd100, 32'd7, 1);
    run_op("div neg pos", FN_DIV, -32'sd100, 32'd7, 1);
    run_op("div pos neg", FN_DIV, 32'd100, -32'sd7, 1);
    run_op("div neg neg", FN_DIV, -32'sd100, -32'sd7, 1);
    run_op("rem neg pos", FN_REM, -32'sd100, 32'd7, 1);
    run_op("rem pos neg", FN_REM, 32'd100, -32'sd7, 1);
    run_op("divu large", FN_DIVU, 32'hFFFF_FFF0, 32'd3, 1);
    run_op("remu large", FN_REMU, 32'hFFFF_FFF0, 32'd7, 1);
    // overflow case, quotient wraps to the most negative value
    run_op("div min by minus one", FN_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 1);
    run_op("rem min by minus one", FN_REM, 32'h8000_0000, 32'hFFFF_FFFF, 1);
  endtask

  task automatic test_div_by_zero();
    imuldiv_fn_t     fn;
    imuldiv_result_u got;
    logic [31:0]     dvd;
    int              resp_edge;
    int              k;
    for (k = 0; k < 8; k++) begin
      // FN_DIV through FN_REMU, negative dividend first
      fn  = imuldiv_fn_t'(3'(1 + k % 4));
      dvd = (k < 4) ? -32'sd12345 : 32'd6789;
      issue_op(fn, dvd, 32'd0);
      wait_resp(got, resp_edge);
      check_equal($sformatf("div by zero fn %0d quot", fn), 32'hFFFF_FFFF, got.div.quot);
      check_equal($sformatf("div by zero fn %0d rem", fn), dvd, got.div.rem);
    end
  endtask

  task automatic test_resp_backpressure();
    imuldiv_result_u exp;
    imuldiv_result_u got;
    int              resp_edge;
    int              i;
    wait_credits_home();
    hold_credits = 1'b1;
    // two responses use up both consumer slots
    run_op("bp fill 0", FN_MUL, 32'h1234_5678, 32'hFFFF_FFF0, 1);
    run_op("bp fill 1", FN_DIVU, 32'hDEAD_BEEF, 32'd1000, 1);
    exp = model_result(FN_REM, -32'sd98765, 32'd321);
    issue_op(FN_REM, -32'sd98765, 32'd321);
    for (i = 0; i < 60; i++) begin
      @(posedge clk);
      #1;
      check_equal("bp no resp while out of credits", 0, resp_q.size());
    end
    // result sits in ST_DONE until a credit returns
    check_equal("bp held result", exp, resp_result);
    hold_credits = 1'b0;
    wait_resp(got, resp_edge);
    check_equal("bp released result", exp, got);
  endtask

  task automatic test_random_ops();
    imuldiv_fn_t fn;
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    for (i = 0; i < 200; i++) begin
      fn = imuldiv_fn_t'(3'($urandom_range(4, 0)));
      a  = $urandom();
      b  = $urandom();
      // steer some operands to the corner values
      case ($urandom_range(7, 0))
        0: b = '0;
        1: b = '1;
        2: a = 32'h8000_0000;
        3: b = $urandom_range(15, 0);
        default: ;
      endcase
      run_op($sformatf("random %0d", i), fn, a, b, 0);
    end
  endtask

  // ------------------------------
  initial begin
    reset   = 1'b1;
    req_val = 1'b0;
    req_fn  = FN_MUL;
    req_a   = '0;
    req_b   = '0;
    void'($urandom(62));
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_equal("reset resp_val", 0, resp_val);
    check_equal("reset req_credit", 0, req_credit);
    test_mul_signs();
    test_div_rem();
    test_div_by_zero();
    test_resp_backpressure();
    test_random_ops();
    wait_credits_home();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/imuldiv_pkg.sv
hdl/imuldiv_ctrl.sv
hdl/imuldiv_mul_dpath.sv
hdl/imuldiv_div_dpath.sv
hdl/imuldiv_result_unit.sv
hdl/imuldiv_iterative.sv
tests/imuldiv_tb.sv

// ==== Makefile ====
# Verilator build and run for the iterative mul/div unit
# exit status of the simulation is the pass or fail result

TOP := imuldiv_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP)

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
